// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Control states of the multicycle core
    typedef enum logic [1:0] {
        FETCH     = 2'd0,
        DECODE    = 2'd1,
        EXECUTE   = 2'd2,
        WRITEBACK = 2'd3
    } state_e;

    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_LUI    = 4'd5,
        OP_CNT_LO = 4'd6,
        OP_CNT_HI = 4'd7,
        OP_BEQ    = 4'd8,
        OP_BNE    = 4'd9,
        OP_NOP    = 4'd10
    } alu_op_e;

    typedef struct packed {
        alu_op_e     op;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  rd;
        logic        use_imm;
        logic [31:0] imm;
        logic        wen;
    } dec_t;

    // Wishbone classic, read only
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

    // Major opcodes, compared against the top bits of the word
    localparam logic [16:0] OPC_ADD     = 17'h00020;
    localparam logic [16:0] OPC_SUB     = 17'h00022;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [9:0]  OPC_ADDI    = 10'h00a;
    localparam logic [6:0]  OPC_LU12I   = 7'h0a;
    // rdcntv*.w include the zero rj field
    localparam logic [21:0] OPC_RDCNTVL = 22'h000018;
    localparam logic [21:0] OPC_RDCNTVH = 22'h000019;
    localparam logic [5:0]  OPC_BEQ     = 6'h16;
    localparam logic [5:0]  OPC_BNE     = 6'h17;

endpackage

`default_nettype wire

// ==== verilog/stable_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module stable_counter (
    input  wire                    aclk,
    input  wire                    reset,
    input  wire core_pkg::alu_op_e op,
    output logic [31:0]            value
);

    logic [63:0] count;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            count <= 64'd0;
        end
        else
        begin
            count <= count + 64'd1;
        end
    end

    // Word select for rdcntvl.w and rdcntvh.w
    always_comb
    begin
        case (op)
            core_pkg::OP_CNT_LO: value = count[31:0];
            core_pkg::OP_CNT_HI: value = count[63:32];
            default:             value = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire [31:0]     inst,
    output core_pkg::dec_t dec
);

    logic [31:0] imm_si12;
    logic [31:0] imm_si20;
    logic [31:0] imm_offs16;

    assign imm_si12   = {{20{inst[21]}}, inst[21:10]};
    assign imm_si20   = {inst[24:5], 12'd0};
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};

    always_comb
    begin
        dec         = '0;
        dec.op      = core_pkg::OP_NOP;
        dec.rd      = inst[4:0];
        dec.rj      = inst[9:5];
        dec.rk      = inst[14:10];

        if (inst[31:15] == core_pkg::OPC_ADD)
        begin
            dec.op = core_pkg::OP_ADD;
        end
        else if (inst[31:15] == core_pkg::OPC_SUB)
        begin
            dec.op = core_pkg::OP_SUB;
        end
        else if (inst[31:15] == core_pkg::OPC_AND)
        begin
            dec.op = core_pkg::OP_AND;
        end
        else if (inst[31:15] == core_pkg::OPC_OR)
        begin
            dec.op = core_pkg::OP_OR;
        end
        else if (inst[31:15] == core_pkg::OPC_XOR)
        begin
            dec.op = core_pkg::OP_XOR;
        end
        else if (inst[31:22] == core_pkg::OPC_ADDI)
        begin
            dec.op      = core_pkg::OP_ADD;
            dec.use_imm = 1'b1;
            dec.imm     = imm_si12;
        end
        else if (inst[31:25] == core_pkg::OPC_LU12I)
        begin
            dec.op  = core_pkg::OP_LUI;
            dec.imm = imm_si20;
        end
        else if (inst[31:10] == core_pkg::OPC_RDCNTVL)
        begin
            dec.op = core_pkg::OP_CNT_LO;
        end
        else if (inst[31:10] == core_pkg::OPC_RDCNTVH)
        begin
            dec.op = core_pkg::OP_CNT_HI;
        end
        else if (inst[31:26] == core_pkg::OPC_BEQ || inst[31:26] == core_pkg::OPC_BNE)
        begin
            // Branches compare rj against rd
            dec.op  = (inst[26]) ? core_pkg::OP_BNE : core_pkg::OP_BEQ;
            dec.rk  = inst[4:0];
            dec.imm = imm_offs16;
        end

        dec.wen = (dec.op != core_pkg::OP_NOP) && (dec.op != core_pkg::OP_BEQ) &&
                  (dec.op != core_pkg::OP_BNE) && (dec.rd != 5'd0);
    end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire         aclk,
    input  wire  [4:0]  raddr1,
    input  wire  [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  wire         we,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata
);

    logic [31:0] regs [0:31];

    // r0 is never stored
    always_ff @(posedge aclk)
    begin
        if (we && waddr != 5'd0)
        begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

    // Decoder clears wen for rd of zero
    assert property (@(posedge aclk)
        we |-> (waddr != 5'd0));

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire core_pkg::dec_t dec,
    input  wire [31:0]          src1,
    input  wire [31:0]          src2,
    input  wire [31:0]          cnt_value,
    output logic [31:0]         result,
    output logic                eq
);

    logic [31:0] opnd_b;

    assign opnd_b = dec.use_imm ? dec.imm : src2;

    // Sums wrap at 32 bits
    always_comb
    begin
        case (dec.op)
            core_pkg::OP_ADD:    result = src1 + opnd_b;
            core_pkg::OP_SUB:    result = src1 - opnd_b;
            core_pkg::OP_AND:    result = src1 & opnd_b;
            core_pkg::OP_OR:     result = src1 | opnd_b;
            core_pkg::OP_XOR:    result = src1 ^ opnd_b;
            core_pkg::OP_LUI:    result = dec.imm;
            core_pkg::OP_CNT_LO: result = cnt_value;
            core_pkg::OP_CNT_HI: result = cnt_value;
            default:             result = 32'd0;
        endcase
    end

    // Branch condition, used by the FSM only
    assign eq = (src1 == src2);

endmodule

`default_nettype wire

// ==== verilog/core_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_ctrl_fsm #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  wire                    aclk,
    input  wire                    reset,
    output core_pkg::wb_req_t      ibus_req,
    input  wire core_pkg::wb_rsp_t ibus_rsp,
    output logic [31:0]            inst,
    input  wire core_pkg::dec_t    dec,
    input  wire [31:0]             alu_result,
    input  wire                    eq,
    output logic                   rf_we,
    output logic [4:0]             rf_waddr,
    output logic [31:0]            rf_wdata,
    output core_pkg::trace_t       trace
);

    core_pkg::state_e state;
    logic [31:0]      pc;
    logic [31:0]      inst_q;
    logic [31:0]      result_q;
    logic             req_active;
    logic             fetch_done;
    logic             branch_taken;
    logic [31:0]      next_pc;

    // Ack outside an open cycle is ignored
    assign fetch_done   = req_active & ibus_rsp.ack;
    assign branch_taken = (dec.op == core_pkg::OP_BEQ && eq) ||
                          (dec.op == core_pkg::OP_BNE && !eq);
    assign next_pc      = branch_taken ? pc + dec.imm : pc + 32'd4;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state      <= core_pkg::FETCH;
            pc         <= RESET_PC;
            req_active <= 1'b0;
        end
        else
        begin
            case (state)
                core_pkg::FETCH:
                begin
                    if (fetch_done)
                    begin
                        state      <= core_pkg::DECODE;
                        req_active <= 1'b0;
                    end
                    else
                    begin
                        // First fetch after reset opens here
                        req_active <= 1'b1;
                    end
                end
                core_pkg::DECODE:
                begin
                    state <= core_pkg::EXECUTE;
                end
                core_pkg::EXECUTE:
                begin
                    state <= core_pkg::WRITEBACK;
                end
                default:
                begin
                    state      <= core_pkg::FETCH;
                    pc         <= next_pc;
                    req_active <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (fetch_done)
        begin
            inst_q <= ibus_rsp.dat;
        end
        if (state == core_pkg::EXECUTE)
        begin
            result_q <= alu_result;
        end
    end

    assign inst     = inst_q;
    assign ibus_req = '{cyc: req_active, stb: req_active, adr: pc};

    assign rf_we    = (state == core_pkg::WRITEBACK) && dec.wen;
    assign rf_waddr = dec.rd;
    assign rf_wdata = result_q;

    assign trace = '{valid: (state == core_pkg::WRITEBACK), pc: pc,
                     we: dec.wen, wnum: dec.rd, wdata: result_q};

    // A request is only open in FETCH
    assert property (@(posedge aclk) disable iff (reset)
        ibus_req.stb |-> (ibus_req.cyc && state == core_pkg::FETCH));

    // Wait states hold the request
    assert property (@(posedge aclk) disable iff (reset)
        (ibus_req.stb && !ibus_rsp.ack) |=> (ibus_req.stb && $stable(ibus_req.adr)));

    // Retire follows one DECODE and one EXECUTE cycle
    assert property (@(posedge aclk) disable iff (reset)
        trace.valid |-> ($past(state) == core_pkg::EXECUTE) &&
                        ($past(state, 2) == core_pkg::DECODE));

endmodule

`default_nettype wire

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  wire                    aclk,
    input  wire                    reset,
    output core_pkg::wb_req_t      ibus_req,
    input  wire core_pkg::wb_rsp_t ibus_rsp,
    output core_pkg::trace_t       trace
);

    logic [31:0]    inst;
    core_pkg::dec_t dec;

    logic [31:0]    rf_rdata1;
    logic [31:0]    rf_rdata2;
    logic           rf_we;
    logic [4:0]     rf_waddr;
    logic [31:0]    rf_wdata;

    logic [31:0]    alu_result;
    logic           alu_eq;
    logic [31:0]    cnt_value;

    core_ctrl_fsm #(
        .RESET_PC   (RESET_PC)
    ) u_ctrl (
        .aclk       (aclk),
        .reset      (reset),
        .ibus_req   (ibus_req),
        .ibus_rsp   (ibus_rsp),
        .inst       (inst),
        .dec        (dec),
        .alu_result (alu_result),
        .eq         (alu_eq),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .trace      (trace)
    );

    inst_decoder u_decoder (
        .inst       (inst),
        .dec        (dec)
    );

    // Read ports follow the decoded source fields
    regfile u_regfile (
        .aclk       (aclk),
        .raddr1     (dec.rj),
        .raddr2     (dec.rk),
        .rdata1     (rf_rdata1),
        .rdata2     (rf_rdata2),
        .we         (rf_we),
        .waddr      (rf_waddr),
        .wdata      (rf_wdata)
    );

    alu u_alu (
        .dec        (dec),
        .src1       (rf_rdata1),
        .src2       (rf_rdata2),
        .cnt_value  (cnt_value),
        .result     (alu_result),
        .eq         (alu_eq)
    );

    stable_counter u_counter (
        .aclk       (aclk),
        .reset      (reset),
        .op         (dec.op),
        .value      (cnt_value)
    );

endmodule

`default_nettype wire

// ==== tests/tb_iss.svh ====
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// Program image and architectural state of the reference model
logic [31:0] prog [0:255];
logic [31:0] model_regs [0:31];
logic [31:0] lcg_state;

// Upper half only, the low LCG bits repeat quickly
function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
endfunction

function automatic void build_program();
    logic [15:0] r;
    logic [15:0] r2;
    logic [7:0]  idx;
    logic [7:0]  room;
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [15:0] offs;
    for (int i = 0; i < 256; i++)
    begin
        idx  = 8'(i);
        room = 8'd255 - idx;
        r    = lcg_next();
        r2   = lcg_next();
        kind = r2[15:12];
        rd   = {2'b00, r[2:0]};
        rj   = {2'b00, r[5:3]};
        rk   = {2'b00, r[8:6]};
        // Forward offset of 1 to 4 words, never past the last word
        offs = {14'd0, r[10:9]} + 16'd1;
        if (offs > {8'd0, room})
            offs = {8'd0, room};
        if ((kind == 4'd11 || kind == 4'd12) && room == 8'd0)
            kind = 4'd5;
        // Prologue gives r1 to r7 a known value
        if (idx < 8'd8)
        begin
            kind = 4'd5;
            rd   = idx[4:0];
            rj   = 5'd0;
        end
        case (kind)
            4'd0:        prog[idx] = {core_pkg::OPC_ADD, rk, rj, rd};
            4'd1:        prog[idx] = {core_pkg::OPC_SUB, rk, rj, rd};
            4'd2:        prog[idx] = {core_pkg::OPC_AND, rk, rj, rd};
            4'd3:        prog[idx] = {core_pkg::OPC_OR, rk, rj, rd};
            4'd4, 4'd14: prog[idx] = {core_pkg::OPC_XOR, rk, rj, rd};
            4'd7, 4'd8:  prog[idx] = {core_pkg::OPC_LU12I, r2[11:0], r[15:8], rd};
            4'd9:        prog[idx] = {core_pkg::OPC_RDCNTVL, 5'd0, rd};
            4'd10:       prog[idx] = {core_pkg::OPC_RDCNTVH, 5'd0, rd};
            4'd11:       prog[idx] = {core_pkg::OPC_BEQ, offs, rj, rd};
            4'd12:       prog[idx] = {core_pkg::OPC_BNE, offs, rj, rd};
            4'd13:       prog[idx] = {2'b11, r[13:0], r2};
            default:     prog[idx] = {core_pkg::OPC_ADDI, r2[11:0], rj, rd};
        endcase
    end
endfunction

// Expected retire record, rdcntvl.w data is bound checked separately
function automatic core_pkg::trace_t predict_retire(input logic [31:0] pc,
                                                    input logic [31:0] w);
    core_pkg::trace_t t;
    logic [31:0]      a;
    logic [31:0]      b;
    a = model_regs[w[9:5]];
    b = model_regs[w[14:10]];
    t = '{valid: 1'b1, pc: pc, we: 1'b1, wnum: w[4:0], wdata: 32'd0};
    if (w[31:15] == core_pkg::OPC_ADD)
        t.wdata = a + b;
    else if (w[31:15] == core_pkg::OPC_SUB)
        t.wdata = a - b;
    else if (w[31:15] == core_pkg::OPC_AND)
        t.wdata = a & b;
    else if (w[31:15] == core_pkg::OPC_OR)
        t.wdata = a | b;
    else if (w[31:15] == core_pkg::OPC_XOR)
        t.wdata = a ^ b;
    else if (w[31:22] == core_pkg::OPC_ADDI)
        t.wdata = a + {{20{w[21]}}, w[21:10]};
    else if (w[31:25] == core_pkg::OPC_LU12I)
        t.wdata = {w[24:5], 12'd0};
    else if (w[31:10] != core_pkg::OPC_RDCNTVL && w[31:10] != core_pkg::OPC_RDCNTVH)
        t.we = 1'b0;
    if (w[4:0] == 5'd0)
        t.we = 1'b0;
    return t;
endfunction

// Branches compare rj with rd
function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc, input logic [31:0] w);
    logic same;
    logic taken;
    same  = model_regs[w[9:5]] == model_regs[w[4:0]];
    taken = (w[31:26] == core_pkg::OPC_BEQ && same) ||
            (w[31:26] == core_pkg::OPC_BNE && !same);
    return taken ? pc + {{14{w[25]}}, w[25:10], 2'b00} : pc + 32'd4;
endfunction

`endif

// ==== tests/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam int          TIMEOUT  = 200;

    logic              aclk = 1'b0;
    logic              reset;
    core_pkg::wb_req_t ibus_req;
    core_pkg::wb_rsp_t ibus_rsp;
    core_pkg::trace_t  trace;

    // Cycles since reset release on the stable counter's time base
    logic [63:0]       cycles;
    logic [31:0]       last_cnt;
    logic              have_cnt;

    `include "tb_iss.svh"

    core_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .aclk     (aclk),
        .reset    (reset),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .trace    (trace)
    );

    always #4 aclk = ~aclk;

    always @(posedge aclk)
    begin
        if (reset)
            cycles <= 64'd0;
        else
            cycles <= cycles + 64'd1;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_fetch(input core_pkg::wb_req_t got, input core_pkg::wb_req_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail ibus_req cyc %h/%h stb %h/%h adr %h/%h (got/expected)",
                                    got.cyc, exp.cyc, got.stb, exp.stb, got.adr, exp.adr));
    endtask

    task automatic check_trace(input core_pkg::trace_t got, input core_pkg::trace_t exp);
        logic bad;
        bad = got.valid !== exp.valid || got.pc !== exp.pc || got.we !== exp.we;
        if (exp.we)
            bad = bad || got.wnum !== exp.wnum || got.wdata !== exp.wdata;
        if (bad)
            stop_on_error($sformatf("Fail trace pc %h/%h we %h/%h wnum %h/%h wdata %h/%h",
                                    got.pc, exp.pc, got.we, exp.we, got.wnum, exp.wnum,
                                    got.wdata, exp.wdata));
    endtask

    // rdcntvl.w must rise and never run ahead of the cycle count
    task automatic check_counter(input logic [31:0] value);
        if ((have_cnt && value <= last_cnt) || {32'd0, value} > cycles)
            stop_on_error($sformatf("Fail trace.wdata rdcntvl.w %h, previous %h, cycles %h",
                                    value, last_cnt, cycles));
        have_cnt = 1'b1;
        last_cnt = value;
    endtask

    task automatic wait_fetch();
        int n;
        n = 0;
        while (!(ibus_req.cyc === 1'b1 && ibus_req.stb === 1'b1))
        begin
            n = n + 1;
            if (n > TIMEOUT)
                stop_on_error("Timeout waiting for a fetch request on the instruction bus");
            @(negedge aclk);
        end
    endtask

    // Wishbone slave with 0 to 3 wait states
    task automatic serve_fetch(input logic [31:0] adr);
        core_pkg::wb_req_t exp;
        logic [15:0]       r;
        exp = '{cyc: 1'b1, stb: 1'b1, adr: adr};
        r   = lcg_next();
        repeat (r[1:0])
        begin
            check_fetch(ibus_req, exp);
            @(negedge aclk);
        end
        check_fetch(ibus_req, exp);
        ibus_rsp = '{ack: 1'b1, dat: prog[adr[9:2] - RESET_PC[9:2]]};
        @(negedge aclk);
        ibus_rsp = '{ack: 1'b0, dat: 32'd0};
        exp.cyc  = 1'b0;
        exp.stb  = 1'b0;
        check_fetch(ibus_req, exp);
    endtask

    // Starts one cycle after the ack cycle
    task automatic wait_retire();
        int n;
        n = 1;
        while (trace.valid !== 1'b1)
        begin
            if (n >= TIMEOUT)
                stop_on_error("Timeout waiting for trace.valid after the fetch ack");
            @(negedge aclk);
            n = n + 1;
        end
        if (n != 3)
            stop_on_error($sformatf("Retire came %0d cycles after the ack instead of 3", n));
    endtask

    initial
    begin
        logic [31:0]       pc;
        logic [31:0]       word;
        logic [31:0]       next_pc;
        core_pkg::trace_t  exp;
        core_pkg::wb_req_t last_req;
        reset      = 1'b1;
        ibus_rsp   = '{ack: 1'b0, dat: 32'd0};
        have_cnt   = 1'b0;
        last_cnt   = 32'd0;
        lcg_state  = 32'h2081_9af6;
        model_regs = '{default: 32'd0};
        build_program();
        pc = RESET_PC;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        while (pc - RESET_PC < 32'd1024)
        begin
            word = prog[pc[9:2] - RESET_PC[9:2]];
            wait_fetch();
            serve_fetch(pc);
            wait_retire();
            exp     = predict_retire(pc, word);
            next_pc = next_fetch_pc(pc, word);
            if (word[31:10] == core_pkg::OPC_RDCNTVL && exp.we)
            begin
                check_counter(trace.wdata);
                // Bound checked value becomes the model's register value
                exp.wdata = trace.wdata;
            end
            check_trace(trace, exp);
            if (exp.we)
                model_regs[exp.wnum] = exp.wdata;
            pc = next_pc;
        end

        // Fetch right after the program must follow the last retire
        wait_fetch();
        last_req = '{cyc: 1'b1, stb: 1'b1, adr: pc};
        check_fetch(ibus_req, last_req);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mini_la_core.f ====
+incdir+tests
verilog/core_pkg.sv
verilog/stable_counter.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/core_ctrl_fsm.sv
verilog/core_top.sv
tests/tb_core.sv

// ==== Makefile ====
# Verilator simulation of the mini LoongArch core

SIM_LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_core --Mdir obj_dir -o tb_core -f mini_la_core.f
	-./obj_dir/tb_core > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@if grep -q "RESULT: FAIL" $(SIM_LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(SIM_LOG); then echo "No result in $(SIM_LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(SIM_LOG)
